// File: logic/cache_pkg.sv
package cache_pkg;

    // Geometry of the cache: 64 lines of one word, 16-bit byte addresses
    localparam int ADDR_W   = 16;
    localparam int DATA_W   = 32;
    localparam int BE_W     = DATA_W / 8;
    localparam int OFFSET_W = 2;
    localparam int INDEX_W  = 6;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int LINES    = 2 ** INDEX_W;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  word_t;
    typedef logic [BE_W-1:0]    be_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    // Request side of the req/gnt/rvalid handshake, used on both ports
    typedef struct packed {
        logic  req;
        addr_t addr;
        logic  we;
        be_t   be;
        word_t wdata;
    } bus_req_t;

    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        word_t rdata;
    } bus_rsp_t;

    // One word transfer handed from the controller to the memory port
    typedef struct packed {
        addr_t addr;
        logic  we;
        word_t wdata;
    } mem_cmd_t;

endpackage

// File: logic/cache_array.sv
`timescale 1ns/10ps

module cache_array
#(
    parameter type entry_t = cache_pkg::word_t,
    parameter int  DEPTH   = cache_pkg::LINES
)
(
    input  logic              clk,
    input  cache_pkg::index_t rd_index_i,
    input  logic              wr_en_i,
    input  cache_pkg::index_t wr_index_i,
    input  entry_t            wr_data_i,
    output entry_t            rd_data_o
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (wr_en_i)
        begin
            mem[wr_index_i] <= wr_data_i;
        end
    end

    // Registered read, data follows the index by one cycle
    always_ff @(posedge clk)
    begin
        rd_data_o <= mem[rd_index_i];
    end

endmodule

// File: logic/mem_port.sv
`timescale 1ns/10ps

module mem_port
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mem_start_i,
    input  cache_pkg::mem_cmd_t mem_cmd_i,
    output cache_pkg::bus_req_t mem_req_o,
    input  cache_pkg::bus_rsp_t mem_rsp_i,
    output logic                mem_done_o,
    output cache_pkg::word_t    mem_rdata_o
);

    typedef enum logic [1:0]
    {
        IDLE,
        WAIT_GNT,
        WAIT_RVALID
    } state_t;

    state_t              state;
    cache_pkg::mem_cmd_t cmd_q;
    cache_pkg::word_t    rdata_q;
    logic                done_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state  <= IDLE;
            done_q <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            case (state)
                IDLE:
                begin
                    // A start while busy cannot reach this branch
                    if (mem_start_i)
                    begin
                        state <= WAIT_GNT;
                    end
                end
                WAIT_GNT:
                begin
                    if (mem_rsp_i.gnt)
                    begin
                        state <= WAIT_RVALID;
                    end
                end
                WAIT_RVALID:
                begin
                    if (mem_rsp_i.rvalid)
                    begin
                        done_q <= 1'b1;
                        state  <= IDLE;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == IDLE && mem_start_i)
        begin
            cmd_q <= mem_cmd_i;
        end
        if (state == WAIT_RVALID && mem_rsp_i.rvalid)
        begin
            rdata_q <= mem_rsp_i.rdata;
        end
    end

    // Whole words only, so every byte lane is enabled
    assign mem_req_o.req   = (state == WAIT_GNT);
    assign mem_req_o.addr  = cmd_q.addr;
    assign mem_req_o.we    = cmd_q.we;
    assign mem_req_o.be    = '1;
    assign mem_req_o.wdata = cmd_q.wdata;

    assign mem_done_o  = done_q;
    assign mem_rdata_o = rdata_q;

endmodule

// File: logic/cache_ctrl.sv
`timescale 1ns/10ps

module cache_ctrl
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  cache_pkg::bus_req_t   proc_req_i,
    output cache_pkg::bus_rsp_t   proc_rsp_o,
    output cache_pkg::index_t     rd_index_o,
    input  cache_pkg::tag_entry_t tag_rd_i,
    input  cache_pkg::word_t      data_rd_i,
    output logic                  tag_wr_en_o,
    output logic                  data_wr_en_o,
    output cache_pkg::index_t     wr_index_o,
    output cache_pkg::tag_entry_t tag_wr_o,
    output cache_pkg::word_t      data_wr_o,
    output logic                  mem_start_o,
    output cache_pkg::mem_cmd_t   mem_cmd_o,
    input  logic                  mem_done_i,
    input  cache_pkg::word_t      mem_rdata_i
);

    typedef enum logic [2:0]
    {
        CLEAR,
        IDLE,
        LOOKUP,
        WRITE_BACK,
        REFILL,
        RESPOND
    } state_t;

    state_t              state;
    cache_pkg::index_t   clear_cnt;
    cache_pkg::bus_req_t req_q;
    cache_pkg::word_t    rdata_q;

    cache_pkg::index_t   req_index;
    cache_pkg::tag_t     req_tag;
    cache_pkg::addr_t    line_addr;
    cache_pkg::addr_t    victim_addr;
    logic                hit;
    logic                dirty_miss;
    cache_pkg::word_t    hit_merged;
    cache_pkg::word_t    refill_merged;

    // Replaces the bytes of old_word whose enable bit is set
    function automatic cache_pkg::word_t merge_bytes(
        input cache_pkg::word_t old_word,
        input cache_pkg::word_t new_word,
        input cache_pkg::be_t   be
    );
        cache_pkg::word_t result;
        result = old_word;
        for (int b = 0; b < cache_pkg::BE_W; b++)
        begin
            if (be[b])
            begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    assign req_index   = req_q.addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
    assign req_tag     = req_q.addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
    assign line_addr   = {req_tag, req_index, {cache_pkg::OFFSET_W{1'b0}}};
    assign victim_addr = {tag_rd_i.tag, req_index, {cache_pkg::OFFSET_W{1'b0}}};

    assign hit        = tag_rd_i.valid && (tag_rd_i.tag == req_tag);
    assign dirty_miss = tag_rd_i.valid && tag_rd_i.dirty && !hit;

    assign hit_merged    = merge_bytes(data_rd_i, req_q.wdata, req_q.be);
    assign refill_merged = req_q.we ? merge_bytes(mem_rdata_i, req_q.wdata, req_q.be)
                                    : mem_rdata_i;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state     <= CLEAR;
            clear_cnt <= '0;
        end
        else
        begin
            case (state)
                CLEAR:
                begin
                    clear_cnt <= clear_cnt + cache_pkg::index_t'(1);
                    if (clear_cnt == cache_pkg::index_t'(cache_pkg::LINES - 1))
                    begin
                        state <= IDLE;
                    end
                end
                IDLE:
                begin
                    if (proc_req_i.req)
                    begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP:
                begin
                    if (hit)
                    begin
                        state <= RESPOND;
                    end
                    else if (dirty_miss)
                    begin
                        state <= WRITE_BACK;
                    end
                    else
                    begin
                        state <= REFILL;
                    end
                end
                WRITE_BACK:
                begin
                    if (mem_done_i)
                    begin
                        state <= REFILL;
                    end
                end
                REFILL:
                begin
                    if (mem_done_i)
                    begin
                        state <= RESPOND;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Stores answer with zero read data
    always_ff @(posedge clk)
    begin
        if (state == IDLE && proc_req_i.req)
        begin
            req_q <= proc_req_i;
        end
        if (state == LOOKUP && hit)
        begin
            rdata_q <= req_q.we ? '0 : data_rd_i;
        end
        if (state == REFILL && mem_done_i)
        begin
            rdata_q <= req_q.we ? '0 : mem_rdata_i;
        end
    end

    always_comb
    begin
        proc_rsp_o.gnt    = (state == IDLE) && proc_req_i.req;
        proc_rsp_o.rvalid = (state == RESPOND);
        proc_rsp_o.rdata  = (state == RESPOND) ? rdata_q : '0;
        // Arrays are read in the gnt cycle straight from the request
        rd_index_o = (state == IDLE) ? proc_req_i.addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W]
                                     : req_index;
    end

    always_comb
    begin
        tag_wr_en_o    = 1'b0;
        data_wr_en_o   = 1'b0;
        wr_index_o     = req_index;
        tag_wr_o.valid = 1'b1;
        tag_wr_o.dirty = req_q.we;
        tag_wr_o.tag   = req_tag;
        data_wr_o      = refill_merged;
        case (state)
            CLEAR:
            begin
                tag_wr_en_o = 1'b1;
                wr_index_o  = clear_cnt;
                tag_wr_o    = '0;
            end
            LOOKUP:
            begin
                if (hit && req_q.we)
                begin
                    tag_wr_en_o  = 1'b1;
                    data_wr_en_o = 1'b1;
                    data_wr_o    = hit_merged;
                end
            end
            REFILL:
            begin
                tag_wr_en_o  = mem_done_i;
                data_wr_en_o = mem_done_i;
            end
            default:
            begin
            end
        endcase
    end

    // Miss handling starts the write-back of a dirty victim, or the refill directly
    always_comb
    begin
        mem_start_o     = 1'b0;
        mem_cmd_o.addr  = line_addr;
        mem_cmd_o.we    = 1'b0;
        mem_cmd_o.wdata = '0;
        if (state == LOOKUP && !hit)
        begin
            mem_start_o = 1'b1;
            if (dirty_miss)
            begin
                mem_cmd_o.addr  = victim_addr;
                mem_cmd_o.we    = 1'b1;
                mem_cmd_o.wdata = data_rd_i;
            end
        end
        if (state == WRITE_BACK && mem_done_i)
        begin
            mem_start_o = 1'b1;
        end
    end

endmodule

// File: logic/cache_top.sv
`timescale 1ns/10ps

module cache_top
(
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::bus_req_t proc_req_i,
    output cache_pkg::bus_rsp_t proc_rsp_o,
    output cache_pkg::bus_req_t mem_req_o,
    input  cache_pkg::bus_rsp_t mem_rsp_i
);

    cache_pkg::index_t     rd_index;
    cache_pkg::index_t     wr_index;
    logic                  tag_wr_en;
    logic                  data_wr_en;
    cache_pkg::tag_entry_t tag_wr;
    cache_pkg::tag_entry_t tag_rd;
    cache_pkg::word_t      data_wr;
    cache_pkg::word_t      data_rd;
    logic                  mem_start;
    cache_pkg::mem_cmd_t   mem_cmd;
    logic                  mem_done;
    cache_pkg::word_t      mem_rdata;

    cache_ctrl ctrl_inst
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .proc_req_i   (proc_req_i),
        .proc_rsp_o   (proc_rsp_o),
        .rd_index_o   (rd_index),
        .tag_rd_i     (tag_rd),
        .data_rd_i    (data_rd),
        .tag_wr_en_o  (tag_wr_en),
        .data_wr_en_o (data_wr_en),
        .wr_index_o   (wr_index),
        .tag_wr_o     (tag_wr),
        .data_wr_o    (data_wr),
        .mem_start_o  (mem_start),
        .mem_cmd_o    (mem_cmd),
        .mem_done_i   (mem_done),
        .mem_rdata_i  (mem_rdata)
    );

    // Both arrays share the read and write index
    cache_array #(.entry_t(cache_pkg::tag_entry_t), .DEPTH(cache_pkg::LINES)) tag_array_inst
    (
        .clk        (clk),
        .rd_index_i (rd_index),
        .wr_en_i    (tag_wr_en),
        .wr_index_i (wr_index),
        .wr_data_i  (tag_wr),
        .rd_data_o  (tag_rd)
    );

    cache_array #(.entry_t(cache_pkg::word_t), .DEPTH(cache_pkg::LINES)) data_array_inst
    (
        .clk        (clk),
        .rd_index_i (rd_index),
        .wr_en_i    (data_wr_en),
        .wr_index_i (wr_index),
        .wr_data_i  (data_wr),
        .rd_data_o  (data_rd)
    );

    mem_port mem_port_inst
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_start_i (mem_start),
        .mem_cmd_i   (mem_cmd),
        .mem_req_o   (mem_req_o),
        .mem_rsp_i   (mem_rsp_i),
        .mem_done_o  (mem_done),
        .mem_rdata_o (mem_rdata)
    );

endmodule

// File: verification/cache_sva.sv
`timescale 1ns/10ps

module cache_sva
(
    input logic                clk,
    input logic                rst_n,
    input cache_pkg::bus_rsp_t proc_rsp_i,
    input cache_pkg::bus_req_t mem_req_i,
    input cache_pkg::bus_rsp_t mem_rsp_i
);

    int fail_count = 0;
    int outstanding;

    // Granted memory requests still waiting for their rvalid
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            outstanding <= 0;
        end
        else
        begin
            outstanding <= outstanding + int'(mem_req_i.req && mem_rsp_i.gnt)
                                       - int'(mem_rsp_i.rvalid);
        end
    end

    property mem_req_held;
        @(posedge clk) disable iff (!rst_n)
        mem_req_i.req && !mem_rsp_i.gnt |=> mem_req_i.req && $stable(mem_req_i);
    endproperty

    property proc_rvalid_not_with_gnt;
        @(posedge clk) disable iff (!rst_n)
        !(proc_rsp_i.rvalid && proc_rsp_i.gnt);
    endproperty

    property mem_rvalid_answers_one_request;
        @(posedge clk) disable iff (!rst_n)
        mem_rsp_i.rvalid |-> outstanding == 1;
    endproperty

    property mem_single_outstanding;
        @(posedge clk) disable iff (!rst_n)
        mem_req_i.req && mem_rsp_i.gnt |-> outstanding == 0;
    endproperty

    assert property (mem_req_held)
    else
    begin
        fail_count++;
        $error("memory request dropped or changed before gnt");
    end

    assert property (proc_rvalid_not_with_gnt)
    else
    begin
        fail_count++;
        $error("processor rvalid and gnt high in the same cycle");
    end

    assert property (mem_rvalid_answers_one_request)
    else
    begin
        fail_count++;
        $error("memory rvalid without exactly one granted request");
    end

    assert property (mem_single_outstanding)
    else
    begin
        fail_count++;
        $error("memory request granted while another is outstanding");
    end

endmodule

bind cache_top cache_sva cache_sva_inst
(
    .clk        (clk),
    .rst_n      (rst_n),
    .proc_rsp_i (proc_rsp_o),
    .mem_req_i  (mem_req_o),
    .mem_rsp_i  (mem_rsp_i)
);

// File: verification/tb_defs.svh
// Initial memory content, a hash of the whole word address
function automatic cache_pkg::word_t initial_word(input int unsigned word_addr);
    return word_addr * 32'h9E37 + 32'h1234;
endfunction

// A store replaces exactly the bytes whose enable bit is set
function automatic cache_pkg::word_t apply_store(
    input cache_pkg::word_t old_word,
    input cache_pkg::word_t wdata,
    input cache_pkg::be_t   be
);
    cache_pkg::word_t result;
    result = old_word;
    for (int b = 0; b < cache_pkg::BE_W; b++)
    begin
        if (be[b])
        begin
            result[8*b +: 8] = wdata[8*b +: 8];
        end
    end
    return result;
endfunction

// File: verification/mem_model.sv
`timescale 1ns/10ps

module mem_model
(
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::bus_req_t mem_req_i,
    output cache_pkg::bus_rsp_t mem_rsp_o
);

    `include "tb_defs.svh"

    typedef enum logic [1:0]
    {
        WAIT_REQ,
        GRANTED,
        DELAY_RSP
    } state_t;

    cache_pkg::word_t    mem [1 << (cache_pkg::ADDR_W - cache_pkg::OFFSET_W)];
    state_t              state;
    int                  delay;
    integer              seed;
    cache_pkg::bus_req_t req_q;

    initial
    begin
        seed = 86;
        state = WAIT_REQ;
        delay = 0;
        mem_rsp_o = '0;
        foreach (mem[i])
        begin
            mem[i] = initial_word(i);
        end
    end

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            state     <= WAIT_REQ;
            delay     <= $random(seed) & 3;
            mem_rsp_o <= '0;
        end
        else
        begin
            mem_rsp_o.gnt    <= 1'b0;
            mem_rsp_o.rvalid <= 1'b0;
            mem_rsp_o.rdata  <= '0;
            case (state)
                WAIT_REQ:
                begin
                    if (mem_req_i.req)
                    begin
                        if (delay == 0)
                        begin
                            mem_rsp_o.gnt <= 1'b1;
                            state         <= GRANTED;
                        end
                        else
                        begin
                            delay <= delay - 1;
                        end
                    end
                end
                GRANTED:
                begin
                    // req and gnt are both high here, so the request transfers now
                    req_q <= mem_req_i;
                    if (mem_req_i.we)
                    begin
                        mem[mem_req_i.addr[15:2]] <= apply_store(mem[mem_req_i.addr[15:2]],
                                                                 mem_req_i.wdata, mem_req_i.be);
                    end
                    delay <= $random(seed) & 3;
                    state <= DELAY_RSP;
                end
                default:
                begin
                    if (delay == 0)
                    begin
                        mem_rsp_o.rvalid <= 1'b1;
                        mem_rsp_o.rdata  <= req_q.we ? '0 : mem[req_q.addr[15:2]];
                        delay            <= $random(seed) & 3;
                        state            <= WAIT_REQ;
                    end
                    else
                    begin
                        delay <= delay - 1;
                    end
                end
            endcase
        end
    end

endmodule

// File: verification/cache_checker.sv
`timescale 1ns/10ps

module cache_checker
(
    input logic                clk,
    input logic                rst_n,
    input cache_pkg::bus_req_t proc_req_i,
    input cache_pkg::bus_rsp_t proc_rsp_i,
    input cache_pkg::bus_req_t mem_req_i,
    input cache_pkg::bus_rsp_t mem_rsp_i
);

    `include "tb_defs.svh"

    cache_pkg::word_t shadow [1 << (cache_pkg::ADDR_W - cache_pkg::OFFSET_W)];
    string            test_name;
    logic             expect_hit;
    int               error_count;
    int               mem_write_count;
    int               cycle;
    int               sweep_cnt;
    logic             seen_edge;

    // The processor transaction in flight is captured at its gnt
    logic             busy;
    string            cur_test;
    cache_pkg::addr_t cur_addr;
    logic             cur_we;
    cache_pkg::word_t cur_expected;
    logic             cur_expect_hit;
    int               cur_gnt_cycle;
    logic             cur_mem_seen;

    initial
    begin
        test_name = "none";
        expect_hit = 1'b0;
        error_count = 0;
        mem_write_count = 0;
        cycle = 0;
        sweep_cnt = 0;
        seen_edge = 1'b0;
        busy = 1'b0;
        foreach (shadow[i])
        begin
            shadow[i] = initial_word(i);
        end
    end

    function automatic cache_pkg::word_t expected_read(input cache_pkg::addr_t addr);
        return shadow[addr[15:2]];
    endfunction

    always @(posedge clk)
    begin
        cycle++;
        if (!rst_n)
        begin
            sweep_cnt = 0;
            busy = 1'b0;
        end
        // No handshake may start during reset or the 64-cycle clear sweep
        if (seen_edge && (!rst_n || sweep_cnt < 64))
        begin
            if (proc_rsp_i.gnt !== 1'b0 || proc_rsp_i.rvalid !== 1'b0
                || mem_req_i.req !== 1'b0)
            begin
                $display("error: handshake activity during reset or clear sweep, cycle %0d",
                         cycle);
                error_count++;
            end
        end
        if (rst_n && sweep_cnt < 64)
        begin
            sweep_cnt++;
        end
        if (rst_n)
        begin
            if (busy && mem_req_i.req)
            begin
                cur_mem_seen = 1'b1;
            end
            if (mem_req_i.req && mem_rsp_i.gnt
                && mem_req_i.be !== {cache_pkg::BE_W{1'b1}})
            begin
                $display("mismatch %s: byte enables to %h expected %h actual %h", cur_test,
                         mem_req_i.addr, {cache_pkg::BE_W{1'b1}}, mem_req_i.be);
                error_count++;
            end
            if (mem_req_i.req && mem_rsp_i.gnt && mem_req_i.we)
            begin
                mem_write_count++;
                if (mem_req_i.wdata !== expected_read(mem_req_i.addr))
                begin
                    $display("mismatch %s: write-back to %h expected %h actual %h", cur_test,
                             mem_req_i.addr, expected_read(mem_req_i.addr), mem_req_i.wdata);
                    error_count++;
                end
            end
            if (proc_rsp_i.rvalid)
            begin
                if (!busy)
                begin
                    $display("error: processor rvalid without a granted request, cycle %0d",
                             cycle);
                    error_count++;
                end
                else
                begin
                    if (proc_rsp_i.rdata !== (cur_we ? '0 : cur_expected))
                    begin
                        $display("mismatch %s: access to %h expected %h actual %h", cur_test,
                                 cur_addr, cur_we ? '0 : cur_expected, proc_rsp_i.rdata);
                        error_count++;
                    end
                    if (cur_expect_hit && cycle - cur_gnt_cycle != 2)
                    begin
                        $display("mismatch %s: hit latency expected %0d actual %0d", cur_test,
                                 2, cycle - cur_gnt_cycle);
                        error_count++;
                    end
                    if (cur_expect_hit && cur_mem_seen)
                    begin
                        $display("error: memory request raised during the hit at %h", cur_addr);
                        error_count++;
                    end
                    busy = 1'b0;
                end
            end
            if (busy && proc_rsp_i.gnt)
            begin
                $display("error: processor gnt while a request is still open, cycle %0d",
                         cycle);
                error_count++;
            end
            if (proc_req_i.req && proc_rsp_i.gnt)
            begin
                busy = 1'b1;
                cur_test = test_name;
                cur_addr = proc_req_i.addr;
                cur_we = proc_req_i.we;
                cur_expected = expected_read(proc_req_i.addr);
                cur_expect_hit = expect_hit;
                cur_gnt_cycle = cycle;
                cur_mem_seen = 1'b0;
                if (proc_req_i.we)
                begin
                    shadow[proc_req_i.addr[15:2]] = apply_store(cur_expected,
                                                                proc_req_i.wdata, proc_req_i.be);
                end
            end
        end
        seen_edge = 1'b1;
    end

endmodule

// File: verification/tb_top.sv
`timescale 1ns/10ps

module tb_top;

    logic                clk = 1'b0;
    logic                rst_n;
    cache_pkg::bus_req_t proc_req;
    cache_pkg::bus_rsp_t proc_rsp;
    cache_pkg::bus_req_t mem_req;
    cache_pkg::bus_rsp_t mem_rsp;
    integer              seed;
    int                  tb_errors;

    always #2 clk = ~clk;

    cache_top cache_top_inst
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .proc_req_i (proc_req),
        .proc_rsp_o (proc_rsp),
        .mem_req_o  (mem_req),
        .mem_rsp_i  (mem_rsp)
    );

    mem_model mem_model_inst
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp)
    );

    cache_checker checker_inst
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .proc_req_i (proc_req),
        .proc_rsp_i (proc_rsp),
        .mem_req_i  (mem_req),
        .mem_rsp_i  (mem_rsp)
    );

    task automatic start_test(input string name, input logic hit);
        checker_inst.test_name = name;
        checker_inst.expect_hit = hit;
        $display("test %s", name);
    endtask

    // Called on a rising edge; returns on the edge that sees rvalid
    task automatic access(input cache_pkg::addr_t addr, input logic we,
                          input cache_pkg::be_t be, input cache_pkg::word_t wdata);
        int   wait_cycles;
        logic granted;
        logic answered;
        proc_req.req   <= 1'b1;
        proc_req.addr  <= addr;
        proc_req.we    <= we;
        proc_req.be    <= be;
        proc_req.wdata <= wdata;
        granted = 1'b0;
        wait_cycles = 0;
        while (!granted && wait_cycles < 200)
        begin
            @(posedge clk);
            granted = proc_rsp.gnt;
            wait_cycles++;
        end
        proc_req.req <= 1'b0;
        if (!granted)
        begin
            $display("error: no gnt for address %h within 200 cycles", addr);
            tb_errors++;
        end
        else
        begin
            answered = 1'b0;
            wait_cycles = 0;
            while (!answered && wait_cycles < 200)
            begin
                @(posedge clk);
                answered = proc_rsp.rvalid;
                wait_cycles++;
            end
            if (!answered)
            begin
                $display("error: no rvalid for address %h within 200 cycles", addr);
                tb_errors++;
            end
        end
    endtask

    initial
    begin
        logic [31:0]      r;
        cache_pkg::addr_t addr;
        int               writes_before;
        int               total;
        rst_n = 1'b0;
        proc_req = '0;
        seed = 86;
        tb_errors = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // The first request waits out the clear sweep
        start_test("reset_read_miss", 1'b0);
        access(16'h0040, 1'b0, 4'h0, 32'h0);
        access(16'h1234, 1'b0, 4'h0, 32'h0);

        start_test("store_hit", 1'b1);
        access(16'h0040, 1'b1, 4'b0101, 32'hA5A5_5A5A);
        access(16'h0040, 1'b0, 4'h0, 32'h0);
        access(16'h1234, 1'b1, 4'b1000, 32'h7700_0000);
        access(16'h1234, 1'b0, 4'h0, 32'h0);

        // 0x0080 and 0x4080 share index 32 with different tags
        start_test("dirty_eviction", 1'b0);
        access(16'h0080, 1'b1, 4'hF, 32'hDEAD_BEEF);
        writes_before = checker_inst.mem_write_count;
        access(16'h4080, 1'b0, 4'h0, 32'h0);
        if (checker_inst.mem_write_count != writes_before + 1)
        begin
            $display("error: read of 4080 did not write back the dirty line of 0080");
            tb_errors++;
        end
        access(16'h0080, 1'b0, 4'h0, 32'h0);

        // Four tags over four indices keep evictions frequent
        start_test("random_traffic", 1'b0);
        for (int n = 0; n < 300; n++)
        begin
            r = $random(seed);
            addr = '0;
            addr[cache_pkg::OFFSET_W +: 2] = r[1:0];
            addr[cache_pkg::OFFSET_W + cache_pkg::INDEX_W +: 2] = r[3:2];
            access(addr, r[4], r[8:5], $random(seed));
        end

        @(posedge clk);
        total = checker_inst.error_count + cache_top_inst.cache_sva_inst.fail_count + tb_errors;
        $display("errors: checker %0d, assertions %0d, testbench %0d",
                 checker_inst.error_count, cache_top_inst.cache_sva_inst.fail_count, tb_errors);
        if (total == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verification
logic/cache_pkg.sv
logic/cache_array.sv
logic/mem_port.sv
logic/cache_ctrl.sv
logic/cache_top.sv
verification/cache_sva.sv
verification/mem_model.sv
verification/cache_checker.sv
verification/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert
TOP       := tb_top
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
RUN_FLAGS := +verilator+error+limit+1000
PASS_TEXT := ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
